/* src.f */
hw/mm_pkg.sv
hw/dma_read.sv
hw/dma_write.sv
hw/dma_engine.sv
hw/mm_engine.sv
hw/matmul_top.sv
dv/axi_mem_model.sv
dv/tb_matmul.sv

/* dv/tb_matmul.sv */
/*
 * matmul accelerator testbench
 * preloads A and B into the memory model, runs jobs, checks C against a reference
 */
`timescale 1ns/1ps

module tb_matmul;

    localparam int DW         = 8;
    localparam int SA_WIDTH   = 4;
    localparam int ACC_W      = 2 * DW + 1;
    localparam int NELEM      = SA_WIDTH * SA_WIDTH;
    localparam int MEM_WORDS  = 1024;
    localparam int MAX_STALL  = 4;
    localparam int A_BASE     = 32'h100;
    localparam int B_BASE     = 32'h200;
    localparam int C_BASE     = 32'h300;
    // ready wait plus response wait per transaction, with slack
    localparam int TXN_CYCLES = 2 * MAX_STALL + 8;
    localparam int JOB_CYCLES = (2 * SA_WIDTH + NELEM) * TXN_CYCLES + SA_WIDTH + 20;
    // nine jobs plus the quiet window after the double start
    localparam int NUM_JOBS   = 10;
    localparam int WATCHDOG_NS = (NUM_JOBS * JOB_CYCLES + 100) * 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] mat_a_addr, mat_b_addr, mat_c_addr;
    logic        start, done, error;
    logic        stall_en, err_en;
    logic [31:0] err_addr;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [1:0]  rresp, bresp;
    logic [3:0]  wstrb;
    logic        arvalid, arready, rvalid, rready;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;

    logic [31:0] a_words [SA_WIDTH];
    logic [31:0] b_words [SA_WIDTH];
    logic [31:0] snap [MEM_WORDS];
    int          checks, test_errs, total_errs, tests_run, tests_failed, cur_test;
    string       test_name;

    always #10 clk = ~clk;

    matmul_top #(.DW(DW), .SA_WIDTH(SA_WIDTH)) DUT (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(mat_a_addr), .mat_b_addr_i(mat_b_addr), .mat_c_addr_i(mat_c_addr),
        .start_i(start), .done_o(done), .error_o(error),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rresp_i(rresp), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
        .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_mem_model #(.MEM_WORDS(MEM_WORDS), .MAX_STALL(MAX_STALL)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .stall_en_i(stall_en), .err_en_i(err_en), .err_addr_i(err_addr),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
        .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready)
    );

    // C(i,j) from the signed DW-bit elements, wrapped to the ACC_W accumulator
    function automatic logic [31:0] ref_elem(input int i, input int j);
        int                   sum;
        logic signed [DW-1:0] ea, eb;
        logic [ACC_W-1:0]     wrapped;
        sum = 0;
        for (int k = 0; k < SA_WIDTH; k++) begin
            ea  = a_words[i][k*DW +: DW];
            eb  = b_words[k][j*DW +: DW];
            sum = sum + int'(ea) * int'(eb);
        end
        wrapped = sum[ACC_W-1:0];
        return {{(32 - ACC_W){wrapped[ACC_W-1]}}, wrapped};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
            test_errs++;
        end
    endtask

    task automatic start_test(input int id, input string name);
        cur_test  = id;
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) tests_failed++;
        $display("test %0d %-14s %0d checks so far, %0d errors", cur_test, test_name,
                 checks, test_errs);
    endtask

    task automatic random_operands();
        for (int r = 0; r < SA_WIDTH; r++) begin
            a_words[r] = $urandom;
            b_words[r] = $urandom;
        end
    endtask

    // operands in, C region overwritten with markers, snapshot taken
    task automatic load_operands();
        for (int r = 0; r < SA_WIDTH; r++) begin
            u_mem.mem[A_BASE / 4 + r] = a_words[r];
            u_mem.mem[B_BASE / 4 + r] = b_words[r];
        end
        for (int e = 0; e < NELEM; e++) begin
            u_mem.mem[C_BASE / 4 + e] = ~(C_BASE + 4 * e);
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            snap[w] = u_mem.mem[w];
        end
    endtask

    task automatic compare_result();
        int n_diff;
        n_diff = 0;
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                check_val($sformatf("mem C(%0d,%0d)", i, j), ref_elem(i, j),
                          u_mem.mem[C_BASE / 4 + i * SA_WIDTH + j]);
            end
        end
        // nothing but C may change
        for (int w = 0; w < MEM_WORDS; w++) begin
            if ((w < C_BASE / 4 || w >= C_BASE / 4 + NELEM) && u_mem.mem[w] !== snap[w]) begin
                n_diff++;
            end
        end
        check_val("mem words changed outside C", 0, n_diff);
    endtask

    task automatic run_job(input logic exp_err, input logic second_start);
        int cyc;
        int dones;
        load_operands();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (second_start) begin
            repeat (5) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        cyc = 0;
        while (done !== 1'b1 && cyc < JOB_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (done !== 1'b1) begin
            $display("test %0d: no done_o pulse within %0d cycles", cur_test, JOB_CYCLES);
            test_errs++;
        end else begin
            check_val("error_o", exp_err, error);
            if (second_start) begin
                dones = 1;
                repeat (JOB_CYCLES) begin
                    @(posedge clk);
                    if (done === 1'b1) dones++;
                end
                check_val("done_o pulse count", 1, dones);
            end
            compare_result();
        end
    endtask

    initial begin : main
        int unsigned seed;
        seed = 32'hda4b;
        void'($urandom(seed));
        rst_n      = 1'b0;
        start      = 1'b0;
        mat_a_addr = A_BASE;
        mat_b_addr = B_BASE;
        mat_c_addr = C_BASE;
        stall_en   = 1'b0;
        err_en     = 1'b0;
        err_addr   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        start_test(1, "idle_outputs");
        repeat (4) begin
            @(posedge clk);
            check_val("done_o", 0, done);
            check_val("error_o", 0, error);
            check_val("arvalid_o", 0, arvalid);
            check_val("rready_o", 0, rready);
            check_val("awvalid_o", 0, awvalid);
            check_val("wvalid_o", 0, wvalid);
            check_val("bready_o", 0, bready);
        end
        end_test();

        // identity A: element r of row r is 1
        start_test(2, "identity_a");
        random_operands();
        for (int r = 0; r < SA_WIDTH; r++) begin
            a_words[r] = 32'd1 << (r * DW);
        end
        run_job(1'b0, 1'b0);
        end_test();

        start_test(3, "random_stalls");
        stall_en <= 1'b1;
        repeat (4) begin
            random_operands();
            run_job(1'b0, 1'b0);
        end
        end_test();

        // every element the most negative value
        start_test(4, "most_negative");
        for (int r = 0; r < SA_WIDTH; r++) begin
            for (int k = 0; k < SA_WIDTH; k++) begin
                a_words[r][k*DW +: DW] = {1'b1, {(DW - 1){1'b0}}};
                b_words[r][k*DW +: DW] = {1'b1, {(DW - 1){1'b0}}};
            end
        end
        run_job(1'b0, 1'b0);
        end_test();

        start_test(5, "double_start");
        random_operands();
        run_job(1'b0, 1'b1);
        end_test();

        // SLVERR on B row 2, then a clean job
        start_test(6, "slave_error");
        @(posedge clk);
        err_addr <= B_BASE + 4 * 2;
        err_en   <= 1'b1;
        random_operands();
        run_job(1'b1, 1'b0);
        @(posedge clk);
        err_en <= 1'b0;
        random_operands();
        run_job(1'b0, 1'b0);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, total_errs);
        if (total_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        mm_pkg::dma_state_t st;
        #(WATCHDOG_NS);
        st = DUT.u_dma.state_q;
        $display("watchdog expired after %0d ns, test %0d (%0s) hung with sequencer in %0s",
                 WATCHDOG_NS, cur_test, test_name, st.name());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* dv/axi_mem_model.sv */
/*
 * AXI slave memory model
 * single-beat reads and writes, random ready and response stalls,
 * optional SLVERR on one address
 */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int MEM_WORDS = 1024,
    parameter int MAX_STALL = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall_en_i,
    input  logic                          err_en_i,
    input  logic [mm_pkg::WORD_W-1:0]     err_addr_i,
    input  logic [mm_pkg::WORD_W-1:0]     araddr_i,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    output logic [mm_pkg::WORD_W-1:0]     rdata_o,
    output logic [1:0]                    rresp_o,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    input  logic [mm_pkg::WORD_W-1:0]     awaddr_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [mm_pkg::WORD_W-1:0]     wdata_i,
    input  logic [mm_pkg::WORD_W/8-1:0]   wstrb_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    output logic [1:0]                    bresp_o,
    output logic                          bvalid_o,
    input  logic                          bready_i
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [mm_pkg::WORD_W-1:0]   mem [MEM_WORDS];
    int unsigned                 ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
    logic                        r_pend, b_pend, aw_got, w_got;
    logic [mm_pkg::WORD_W-1:0]   aw_addr, w_data;
    logic [mm_pkg::WORD_W/8-1:0] w_strb;

    // every word starts out marked with its own byte address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc3c3_0000 ^ (i * 4);
        end
    end

    // wait length for the next ready or response
    function automatic int unsigned stall_len();
        if (stall_en_i) begin
            return $urandom % (MAX_STALL + 1);
        end
        return 0;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            rvalid_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= mm_pkg::RESP_OKAY;
            bresp_o   <= mm_pkg::RESP_OKAY;
            r_pend    <= 1'b0;
            b_pend    <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_cnt    <= 0;
            aw_cnt    <= 0;
            w_cnt     <= 0;
            r_cnt     <= 0;
            b_cnt     <= 0;
        end else begin
            // ready rises only while valid waits, after a random count
            if (arvalid_i && !arready_o) begin
                if (ar_cnt == 0) arready_o <= 1'b1;
                else ar_cnt <= ar_cnt - 1;
            end else begin
                arready_o <= 1'b0;
                ar_cnt    <= stall_len();
            end
            if (awvalid_i && !awready_o) begin
                if (aw_cnt == 0) awready_o <= 1'b1;
                else aw_cnt <= aw_cnt - 1;
            end else begin
                awready_o <= 1'b0;
                aw_cnt    <= stall_len();
            end
            if (wvalid_i && !wready_o) begin
                if (w_cnt == 0) wready_o <= 1'b1;
                else w_cnt <= w_cnt - 1;
            end else begin
                wready_o <= 1'b0;
                w_cnt    <= stall_len();
            end

            // read: fetch on AR, return after a delay
            if (arvalid_i && arready_o) begin
                r_pend  <= 1'b1;
                r_cnt   <= stall_len();
                rdata_o <= mem[araddr_i[IDX_W+1:2]];
                rresp_o <= (err_en_i && araddr_i == err_addr_i) ?
                           mm_pkg::RESP_SLVERR : mm_pkg::RESP_OKAY;
            end
            if (r_pend && !rvalid_o) begin
                if (r_cnt == 0) rvalid_o <= 1'b1;
                else r_cnt <= r_cnt - 1;
            end
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                r_pend   <= 1'b0;
            end

            // write: AW and W may arrive in either order
            if (awvalid_i && awready_o) begin
                aw_got  <= 1'b1;
                aw_addr <= awaddr_i;
            end
            if (wvalid_i && wready_o) begin
                w_got  <= 1'b1;
                w_data <= wdata_i;
                w_strb <= wstrb_i;
            end
            if (aw_got && w_got) begin
                for (int b = 0; b < mm_pkg::WORD_W / 8; b++) begin
                    if (w_strb[b]) mem[aw_addr[IDX_W+1:2]][b*8 +: 8] <= w_data[b*8 +: 8];
                end
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                b_pend  <= 1'b1;
                b_cnt   <= stall_len();
                bresp_o <= (err_en_i && aw_addr == err_addr_i) ?
                           mm_pkg::RESP_SLVERR : mm_pkg::RESP_OKAY;
            end
            if (b_pend && !bvalid_o) begin
                if (b_cnt == 0) bvalid_o <= 1'b1;
                else b_cnt <= b_cnt - 1;
            end
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                b_pend   <= 1'b0;
            end
        end
    end

endmodule

/* hw/matmul_top.sv */
/*
 * matmul accelerator top
 * DMA sequencer plus multiply engine on AXI read and write ports
 */
`timescale 1ns/1ps

module matmul_top #(
    parameter int DW       = 8,
    parameter int SA_WIDTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mm_pkg::WORD_W-1:0]     mat_a_addr_i,
    input  logic [mm_pkg::WORD_W-1:0]     mat_b_addr_i,
    input  logic [mm_pkg::WORD_W-1:0]     mat_c_addr_i,
    input  logic                          start_i,
    output logic                          done_o,
    output logic                          error_o,
    output logic [mm_pkg::WORD_W-1:0]     araddr_o,
    output logic                          arvalid_o,
    input  logic                          arready_i,
    input  logic [mm_pkg::WORD_W-1:0]     rdata_i,
    input  logic [1:0]                    rresp_i,
    input  logic                          rvalid_i,
    output logic                          rready_o,
    output logic [mm_pkg::WORD_W-1:0]     awaddr_o,
    output logic                          awvalid_o,
    input  logic                          awready_i,
    output logic [mm_pkg::WORD_W-1:0]     wdata_o,
    output logic [mm_pkg::WORD_W/8-1:0]   wstrb_o,
    output logic                          wvalid_o,
    input  logic                          wready_i,
    input  logic [1:0]                    bresp_i,
    input  logic                          bvalid_i,
    output logic                          bready_o
);

    // buffer fill and engine handshake
    logic                                  buf_a_we, buf_b_we;
    logic [$clog2(SA_WIDTH)-1:0]           buf_row;
    logic [SA_WIDTH*DW-1:0]                buf_data;
    logic                                  mm_start, mm_done;
    logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0] accum;

    dma_engine #(.DW(DW), .SA_WIDTH(SA_WIDTH)) u_dma (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(mat_a_addr_i), .mat_b_addr_i(mat_b_addr_i),
        .mat_c_addr_i(mat_c_addr_i), .start_i(start_i),
        .done_o(done_o), .error_o(error_o),
        .araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i(rdata_i), .rresp_i(rresp_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
        .awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
        .wdata_o(wdata_o), .wstrb_o(wstrb_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
        .bresp_i(bresp_i), .bvalid_i(bvalid_i), .bready_o(bready_o),
        .buf_a_we_o(buf_a_we), .buf_b_we_o(buf_b_we),
        .buf_row_o(buf_row), .buf_data_o(buf_data),
        .mm_start_o(mm_start), .mm_done_i(mm_done), .accum_i(accum)
    );

    mm_engine #(.DW(DW), .SA_WIDTH(SA_WIDTH)) u_mm (
        .clk(clk), .rst_n(rst_n),
        .buf_a_we_i(buf_a_we), .buf_b_we_i(buf_b_we),
        .buf_row_i(buf_row), .buf_data_i(buf_data),
        .start_i(mm_start), .done_o(mm_done), .accum_o(accum)
    );

endmodule

/* hw/mm_engine.sv */
/*
 * matrix multiply engine
 * A/B row buffers and a parallel MAC array, one k step per cycle
 */
`timescale 1ns/1ps

module mm_engine #(
    parameter int DW       = 8,
    parameter int SA_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   buf_a_we_i,
    input  logic                                   buf_b_we_i,
    input  logic [$clog2(SA_WIDTH)-1:0]            buf_row_i,
    input  logic [SA_WIDTH*DW-1:0]                 buf_data_i,
    input  logic                                   start_i,
    output logic                                   done_o,
    output logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0]  accum_o
);

    localparam int ACC_W = 2 * DW + 1;
    localparam int K_W   = $clog2(SA_WIDTH);

    // element k of a row lives at bits k*DW
    logic [SA_WIDTH*DW-1:0]  a_rows [SA_WIDTH];
    logic [SA_WIDTH*DW-1:0]  b_rows [SA_WIDTH];
    logic signed [ACC_W-1:0] acc    [SA_WIDTH][SA_WIDTH];
    logic [K_W-1:0]          k_q;
    logic                    run_q;

    // operand buffers
    always_ff @(posedge clk) begin
        if (buf_a_we_i) begin
            a_rows[buf_row_i] <= buf_data_i;
        end
        if (buf_b_we_i) begin
            b_rows[buf_row_i] <= buf_data_i;
        end
    end

    // step sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_q    <= '0;
            run_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                k_q   <= '0;
                run_q <= 1'b1;
            end else if (run_q) begin
                k_q <= k_q + 1'b1;
                // last step lands with done
                if (k_q == K_W'(SA_WIDTH - 1)) begin
                    run_q  <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // MAC array
    always_ff @(posedge clk) begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                if (start_i) begin
                    acc[i][j] <= '0;
                end else if (run_q) begin
                    // signed operands widen to ACC_W before the multiply
                    acc[i][j] <= acc[i][j]
                                 + $signed(a_rows[i][k_q*DW +: DW])
                                 * $signed(b_rows[k_q][j*DW +: DW]);
                end
            end
        end
    end

    // flatten row-major
    for (genvar gi = 0; gi < SA_WIDTH; gi++) begin : g_row
        for (genvar gj = 0; gj < SA_WIDTH; gj++) begin : g_col
            assign accum_o[(gi*SA_WIDTH+gj)*ACC_W +: ACC_W] = acc[gi][gj];
        end
    end

endmodule

/* hw/dma_engine.sv */
/*
 * DMA job sequencer
 * fetches A and B, kicks the multiply engine, writes C back, reports done and error
 */
`timescale 1ns/1ps

module dma_engine #(
    parameter int DW       = 8,
    parameter int SA_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [mm_pkg::WORD_W-1:0]              mat_a_addr_i,
    input  logic [mm_pkg::WORD_W-1:0]              mat_b_addr_i,
    input  logic [mm_pkg::WORD_W-1:0]              mat_c_addr_i,
    input  logic                                   start_i,
    output logic                                   done_o,
    output logic                                   error_o,
    output logic [mm_pkg::WORD_W-1:0]              araddr_o,
    output logic                                   arvalid_o,
    input  logic                                   arready_i,
    input  logic [mm_pkg::WORD_W-1:0]              rdata_i,
    input  logic [1:0]                             rresp_i,
    input  logic                                   rvalid_i,
    output logic                                   rready_o,
    output logic [mm_pkg::WORD_W-1:0]              awaddr_o,
    output logic                                   awvalid_o,
    input  logic                                   awready_i,
    output logic [mm_pkg::WORD_W-1:0]              wdata_o,
    output logic [mm_pkg::WORD_W/8-1:0]            wstrb_o,
    output logic                                   wvalid_o,
    input  logic                                   wready_i,
    input  logic [1:0]                             bresp_i,
    input  logic                                   bvalid_i,
    output logic                                   bready_o,
    output logic                                   buf_a_we_o,
    output logic                                   buf_b_we_o,
    output logic [$clog2(SA_WIDTH)-1:0]            buf_row_o,
    output logic [SA_WIDTH*DW-1:0]                 buf_data_o,
    output logic                                   mm_start_o,
    input  logic                                   mm_done_i,
    input  logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0]  accum_i
);

    mm_pkg::dma_state_t state_q;
    logic [mm_pkg::WORD_W-1:0] a_base_q, b_base_q, c_base_q;
    logic rd_start, rd_done, rd_err;
    logic wr_start, wr_done, wr_err;
    logic err_q;

    // RUN_MM lasts a single cycle
    assign mm_start_o = (state_q == mm_pkg::RUN_MM);
    assign done_o     = (state_q == mm_pkg::FINISH);
    assign error_o    = err_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= mm_pkg::IDLE;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            // sticky, cleared on accepted start
            if (state_q == mm_pkg::IDLE && start_i) begin
                err_q <= 1'b0;
            end else if (rd_err || wr_err) begin
                err_q <= 1'b1;
            end
            case (state_q)
                mm_pkg::IDLE: begin
                    if (start_i) begin
                        rd_start <= 1'b1;
                        state_q  <= mm_pkg::READ_AB;
                    end
                end
                mm_pkg::READ_AB: if (rd_done) state_q <= mm_pkg::RUN_MM;
                mm_pkg::RUN_MM:  state_q <= mm_pkg::WAIT_MM;
                mm_pkg::WAIT_MM: begin
                    if (mm_done_i) begin
                        wr_start <= 1'b1;
                        state_q  <= mm_pkg::WRITE_C;
                    end
                end
                mm_pkg::WRITE_C: if (wr_done) state_q <= mm_pkg::FINISH;
                default:         state_q <= mm_pkg::IDLE;
            endcase
        end
    end

    // job addresses, held for the whole job
    always_ff @(posedge clk) begin
        if (state_q == mm_pkg::IDLE && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
        end
    end

    dma_read #(.DW(DW), .SA_WIDTH(SA_WIDTH)) u_rd (
        .clk(clk), .rst_n(rst_n), .start_i(rd_start),
        .a_base_i(a_base_q), .b_base_i(b_base_q),
        .araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i(rdata_i), .rresp_i(rresp_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
        .buf_a_we_o(buf_a_we_o), .buf_b_we_o(buf_b_we_o),
        .buf_row_o(buf_row_o), .buf_data_o(buf_data_o),
        .done_o(rd_done), .err_o(rd_err)
    );

    dma_write #(.DW(DW), .SA_WIDTH(SA_WIDTH)) u_wr (
        .clk(clk), .rst_n(rst_n), .start_i(wr_start),
        .c_base_i(c_base_q), .accum_i(accum_i),
        .awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
        .wdata_o(wdata_o), .wstrb_o(wstrb_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
        .bresp_i(bresp_i), .bvalid_i(bvalid_i), .bready_o(bready_o),
        .done_o(wr_done), .err_o(wr_err)
    );

endmodule

/* hw/dma_write.sv */
/*
 * result writeback master
 * stores every C accumulator, sign-extended, one AXI write per word
 */
`timescale 1ns/1ps

module dma_write #(
    parameter int DW       = 8,
    parameter int SA_WIDTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    input  logic [mm_pkg::WORD_W-1:0]              c_base_i,
    input  logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0]  accum_i,
    output logic [mm_pkg::WORD_W-1:0]              awaddr_o,
    output logic                                   awvalid_o,
    input  logic                                   awready_i,
    output logic [mm_pkg::WORD_W-1:0]              wdata_o,
    output logic [mm_pkg::WORD_W/8-1:0]            wstrb_o,
    output logic                                   wvalid_o,
    input  logic                                   wready_i,
    input  logic [1:0]                             bresp_i,
    input  logic                                   bvalid_i,
    output logic                                   bready_o,
    output logic                                   done_o,
    output logic                                   err_o
);

    localparam int ACC_W = 2 * DW + 1;
    localparam int NELEM = SA_WIDTH * SA_WIDTH;
    localparam int IDX_W = $clog2(NELEM);

    logic [IDX_W-1:0]        idx_q;
    logic signed [ACC_W-1:0] acc_sel;
    logic                    last_elem;
    logic                    aw_left;
    logic                    w_left;

    assign last_elem = (idx_q == IDX_W'(NELEM - 1));

    // row-major element (i,j) sits at index i*SA_WIDTH+j
    assign acc_sel  = accum_i[idx_q*ACC_W +: ACC_W];
    assign wdata_o  = {{(mm_pkg::WORD_W - ACC_W){acc_sel[ACC_W-1]}}, acc_sel};
    assign awaddr_o = c_base_i + mm_pkg::WORD_W'({idx_q, 2'b00});
    assign wstrb_o  = '1;

    // channel still unaccepted after this cycle
    assign aw_left = awvalid_o && !awready_i;
    assign w_left  = wvalid_o && !wready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q     <= '0;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            bready_o  <= 1'b0;
            done_o    <= 1'b0;
            err_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            err_o  <= 1'b0;
            if (start_i) begin
                idx_q     <= '0;
                awvalid_o <= 1'b1;
                wvalid_o  <= 1'b1;
            end
            // each channel drops on its own handshake
            if (awvalid_o && awready_i) begin
                awvalid_o <= 1'b0;
            end
            if (wvalid_o && wready_i) begin
                wvalid_o <= 1'b0;
            end
            // both accepted, open for the response
            if ((awvalid_o || wvalid_o) && !aw_left && !w_left) begin
                bready_o <= 1'b1;
            end
            if (bvalid_i && bready_o) begin
                bready_o <= 1'b0;
                err_o    <= (bresp_i != mm_pkg::RESP_OKAY);
                if (last_elem) begin
                    done_o <= 1'b1;
                end else begin
                    idx_q     <= idx_q + 1'b1;
                    awvalid_o <= 1'b1;
                    wvalid_o  <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/dma_read.sv */
/*
 * operand fetch master
 * single-beat AXI reads of the A then B rows into the operand buffers
 */
`timescale 1ns/1ps

module dma_read #(
    parameter int DW       = 8,
    parameter int SA_WIDTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [mm_pkg::WORD_W-1:0]    a_base_i,
    input  logic [mm_pkg::WORD_W-1:0]    b_base_i,
    output logic [mm_pkg::WORD_W-1:0]    araddr_o,
    output logic                         arvalid_o,
    input  logic                         arready_i,
    input  logic [mm_pkg::WORD_W-1:0]    rdata_i,
    input  logic [1:0]                   rresp_i,
    input  logic                         rvalid_i,
    output logic                         rready_o,
    output logic                         buf_a_we_o,
    output logic                         buf_b_we_o,
    output logic [$clog2(SA_WIDTH)-1:0]  buf_row_o,
    output logic [SA_WIDTH*DW-1:0]       buf_data_o,
    output logic                         done_o,
    output logic                         err_o
);

    localparam int ROW_W = $clog2(SA_WIDTH);

    logic [ROW_W-1:0] row_q;
    // 0 while fetching A, 1 while fetching B
    logic             phase_b_q;
    logic             last_row;
    logic             r_hs;

    assign last_row = (row_q == ROW_W'(SA_WIDTH - 1));
    assign r_hs     = rvalid_i && rready_o;

    // one row per word, rows 4 bytes apart
    assign araddr_o = (phase_b_q ? b_base_i : a_base_i) + mm_pkg::WORD_W'({row_q, 2'b00});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q      <= '0;
            phase_b_q  <= 1'b0;
            arvalid_o  <= 1'b0;
            rready_o   <= 1'b0;
            buf_a_we_o <= 1'b0;
            buf_b_we_o <= 1'b0;
            done_o     <= 1'b0;
            err_o      <= 1'b0;
        end else begin
            // pulses by default
            buf_a_we_o <= 1'b0;
            buf_b_we_o <= 1'b0;
            done_o     <= 1'b0;
            err_o      <= 1'b0;
            if (start_i) begin
                row_q     <= '0;
                phase_b_q <= 1'b0;
                arvalid_o <= 1'b1;
            end
            // address accepted, now wait for the data beat
            if (arvalid_o && arready_i) begin
                arvalid_o <= 1'b0;
                rready_o  <= 1'b1;
            end
            if (r_hs) begin
                rready_o   <= 1'b0;
                buf_a_we_o <= !phase_b_q;
                buf_b_we_o <= phase_b_q;
                // bad response still writes the row
                err_o      <= (rresp_i != mm_pkg::RESP_OKAY);
                if (phase_b_q && last_row) begin
                    done_o <= 1'b1;
                end else begin
                    arvalid_o <= 1'b1;
                    if (last_row) begin
                        row_q     <= '0;
                        phase_b_q <= 1'b1;
                    end else begin
                        row_q <= row_q + 1'b1;
                    end
                end
            end
        end
    end

    // row payload, written one cycle after the R handshake
    always_ff @(posedge clk) begin
        if (r_hs) begin
            buf_row_o  <= row_q;
            buf_data_o <= rdata_i[SA_WIDTH*DW-1:0];
        end
    end

endmodule

/* hw/mm_pkg.sv */
/*
 * matmul accelerator shared definitions
 * sequencer states, AXI response codes and memory word width
 */
package mm_pkg;

    // memory data and address width
    parameter int WORD_W = 32;

    // AXI response encodings
    parameter logic [1:0] RESP_OKAY   = 2'b00;
    parameter logic [1:0] RESP_SLVERR = 2'b10;

    // job sequencer states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        READ_AB = 3'd1,
        RUN_MM  = 3'd2,
        WAIT_MM = 3'd3,
        WRITE_C = 3'd4,
        FINISH  = 3'd5
    } dma_state_t;

endpackage
